// File: dv/rename_tb.sv
/*
 * rename stage testbench
 * directed tests against a reference model of the map, free list,
 * active list, busy bits and branch checkpoints
 */
`timescale 1ns/100ps
`default_nettype none

module rename_tb;

    // about 70 requests of 3 to 4 cycles each plus resets and resolves fit well below this
    localparam int MAX_CYCLES = 1000;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  ren_valid;
    rename_pkg::arch_reg_t ren_rs;
    rename_pkg::arch_reg_t ren_rt;
    logic                  ren_uses_rw;
    rename_pkg::arch_reg_t ren_rw;
    logic                  ren_is_branch;
    logic                  ren_stall;
    logic                  wb_valid;
    rename_pkg::phys_reg_t wb_phys;
    logic                  commit_valid;
    logic                  resolve_valid;
    logic                  resolve_mispredict;
    logic                  out_valid;
    rename_pkg::phys_reg_t out_rs_phys;
    rename_pkg::phys_reg_t out_rt_phys;
    rename_pkg::phys_reg_t out_rw_phys;
    rename_pkg::phys_reg_t out_old_phys;
    logic                  out_rs_ready;
    logic                  out_rt_ready;

    integer seed = 32'h5c3b;
    int     cycles = 0;

    // reference model
    rename_pkg::phys_reg_t ref_map [rename_pkg::NUM_ARCH_REGS];
    logic                  ref_busy [rename_pkg::NUM_PHYS_REGS];
    rename_pkg::phys_reg_t free_q [$];
    rename_pkg::phys_reg_t al_q [$];
    // every allocation in order and trimmed on a mispredict
    rename_pkg::phys_reg_t alloc_hist [$];
    rename_pkg::phys_reg_t ck_map [rename_pkg::NUM_CHECKPOINTS][rename_pkg::NUM_ARCH_REGS];
    int                    ck_allocs [rename_pkg::NUM_CHECKPOINTS];
    int                    ck_count;

    // request currently presented
    rename_pkg::arch_reg_t req_rs;
    rename_pkg::arch_reg_t req_rt;
    rename_pkg::arch_reg_t req_rw;
    logic                  req_uses_rw;
    logic                  req_branch;
    logic                  req_wb;
    rename_pkg::phys_reg_t req_wb_phys;
    logic                  req_pending = 1'b0;

    rename_top DUT (
        .clk(clk), .rst_n(rst_n),
        .ren_valid(ren_valid), .ren_rs(ren_rs), .ren_rt(ren_rt),
        .ren_uses_rw(ren_uses_rw), .ren_rw(ren_rw), .ren_is_branch(ren_is_branch),
        .ren_stall(ren_stall),
        .wb_valid(wb_valid), .wb_phys(wb_phys), .commit_valid(commit_valid),
        .resolve_valid(resolve_valid), .resolve_mispredict(resolve_mispredict),
        .out_valid(out_valid), .out_rs_phys(out_rs_phys), .out_rt_phys(out_rt_phys),
        .out_rw_phys(out_rw_phys), .out_old_phys(out_old_phys),
        .out_rs_ready(out_rs_ready), .out_rt_ready(out_rt_ready)
    );

    always #50 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, DUT never finished the tests", cycles);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic rename_pkg::arch_reg_t rand_reg();
        return rename_pkg::arch_reg_t'($random(seed));
    endfunction

    // stall as the handshake rules predict it
    function automatic logic model_stall(input logic uses_rw, input logic is_branch);
        return (uses_rw && free_q.size() == 0) ||
               (is_branch && ck_count == rename_pkg::NUM_CHECKPOINTS);
    endfunction

    task automatic reset_dut();
        @(posedge clk);
        rst_n              <= 1'b0;
        ren_valid          <= 1'b0;
        ren_uses_rw        <= 1'b0;
        ren_is_branch      <= 1'b0;
        wb_valid           <= 1'b0;
        commit_valid       <= 1'b0;
        resolve_valid      <= 1'b0;
        resolve_mispredict <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        // identity map with p32..p63 free and nothing busy
        for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
            ref_map[i] = rename_pkg::phys_reg_t'(i);
        end
        for (int i = 0; i < rename_pkg::NUM_PHYS_REGS; i++) begin
            ref_busy[i] = 1'b0;
        end
        free_q.delete();
        al_q.delete();
        alloc_hist.delete();
        for (int i = 0; i < rename_pkg::NUM_FREE; i++) begin
            free_q.push_back(rename_pkg::phys_reg_t'(rename_pkg::NUM_FREE + i));
        end
        ck_count = 0;
    endtask

    task automatic present_req(input rename_pkg::arch_reg_t rs, input rename_pkg::arch_reg_t rt,
                               input logic uses_rw, input rename_pkg::arch_reg_t rw,
                               input logic is_branch, input logic with_wb,
                               input rename_pkg::phys_reg_t wb_reg);
        @(posedge clk);
        ren_valid     <= 1'b1;
        ren_rs        <= rs;
        ren_rt        <= rt;
        ren_uses_rw   <= uses_rw;
        ren_rw        <= rw;
        ren_is_branch <= is_branch;
        wb_valid      <= with_wb;
        wb_phys       <= wb_reg;
        req_rs      = rs;
        req_rt      = rt;
        req_rw      = rw;
        req_uses_rw = uses_rw;
        req_branch  = is_branch;
        req_wb      = with_wb;
        req_wb_phys = wb_reg;
        req_pending = 1'b1;
    endtask

    // wait for accept, update the model and check the one-cycle result
    task automatic finish_req();
        rename_pkg::phys_reg_t exp_rs;
        rename_pkg::phys_reg_t exp_rt;
        rename_pkg::phys_reg_t exp_new;
        rename_pkg::phys_reg_t exp_old;
        logic                  exp_rs_rdy;
        logic                  exp_rt_rdy;
        @(negedge clk);
        check("ren_stall", ren_stall, model_stall(req_uses_rw, req_branch));
        while (ren_stall) @(negedge clk);
        // sources see the map before this instruction's own write
        exp_rs = ref_map[req_rs];
        exp_rt = ref_map[req_rt];
        exp_rs_rdy = !ref_busy[exp_rs] || (req_wb && req_wb_phys == exp_rs);
        exp_rt_rdy = !ref_busy[exp_rt] || (req_wb && req_wb_phys == exp_rt);
        exp_new = req_uses_rw ? free_q[0] : '0;
        exp_old = ref_map[req_rw];
        @(posedge clk);
        ren_valid   <= 1'b0;
        wb_valid    <= 1'b0;
        req_pending = 1'b0;
        if (req_wb) begin
            ref_busy[req_wb_phys] = 1'b0;
        end
        if (req_uses_rw) begin
            free_q.delete(0);
            ref_map[req_rw] = exp_new;
            ref_busy[exp_new] = 1'b1;
            al_q.push_back(exp_old);
            alloc_hist.push_back(exp_new);
        end
        // snapshot taken after the branch's own destination
        if (req_branch) begin
            for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
                ck_map[ck_count][i] = ref_map[i];
            end
            ck_allocs[ck_count] = alloc_hist.size();
            ck_count++;
        end
        @(negedge clk);
        check("out_valid", out_valid, 1'b1);
        check("out_rs_phys", out_rs_phys, exp_rs);
        check("out_rt_phys", out_rt_phys, exp_rt);
        check("out_rs_ready", out_rs_ready, exp_rs_rdy);
        check("out_rt_ready", out_rt_ready, exp_rt_rdy);
        if (req_uses_rw) begin
            check("out_rw_phys", out_rw_phys, exp_new);
            check("out_old_phys", out_old_phys, exp_old);
        end
        @(negedge clk);
        check("out_valid", out_valid, 1'b0);
    endtask

    task automatic rename_op(input rename_pkg::arch_reg_t rs, input rename_pkg::arch_reg_t rt,
                             input logic uses_rw, input rename_pkg::arch_reg_t rw,
                             input logic is_branch);
        present_req(rs, rt, uses_rw, rw, is_branch, 1'b0, '0);
        finish_req();
    endtask

    task automatic write_back(input rename_pkg::phys_reg_t p);
        @(posedge clk);
        wb_valid <= 1'b1;
        wb_phys  <= p;
        @(posedge clk);
        wb_valid <= 1'b0;
        ref_busy[p] = 1'b0;
    endtask

    task automatic commit_one();
        @(posedge clk);
        commit_valid <= 1'b1;
        @(posedge clk);
        commit_valid <= 1'b0;
        free_q.push_back(al_q[0]);
        al_q.delete(0);
    endtask

    task automatic resolve_branch(input logic mispredict);
        int n;
        @(posedge clk);
        resolve_valid      <= 1'b1;
        resolve_mispredict <= mispredict;
        @(negedge clk);
        check("ren_stall", ren_stall,
              mispredict | (req_pending & model_stall(req_uses_rw, req_branch)));
        @(posedge clk);
        resolve_valid      <= 1'b0;
        resolve_mispredict <= 1'b0;
        if (mispredict) begin
            // registers allocated since the branch go back to the head
            n = alloc_hist.size() - ck_allocs[0];
            for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
                ref_map[i] = ck_map[0][i];
            end
            repeat (n) begin
                free_q.push_front(alloc_hist.pop_back());
                al_q.delete(al_q.size() - 1);
            end
            ck_count = 0;
        end else begin
            for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
                ck_map[0][i] = ck_map[1][i];
            end
            ck_allocs[0] = ck_allocs[1];
            ck_count--;
        end
    endtask

    task automatic lookup_after_reset();
        reset_dut();
        rename_op(5'd3, 5'd7, 1'b1, 5'd5, 1'b0);
        check("out_rs_phys", out_rs_phys, 6'd3);
        check("out_rt_phys", out_rt_phys, 6'd7);
        check("out_rw_phys", out_rw_phys, 6'd32);
        check("out_old_phys", out_old_phys, 6'd5);
        // consumer of r5 sees the fresh, still busy register
        rename_op(5'd5, 5'd0, 1'b0, 5'd0, 1'b0);
        check("out_rs_phys", out_rs_phys, 6'd32);
        check("out_rs_ready", out_rs_ready, 1'b0);
    endtask

    task automatic writeback_sets_ready();
        rename_pkg::phys_reg_t p;
        write_back(6'd32);
        rename_op(5'd5, 5'd1, 1'b0, 5'd0, 1'b0);
        check("out_rs_ready", out_rs_ready, 1'b1);
        rename_op(5'd0, 5'd0, 1'b1, 5'd6, 1'b0);
        p = ref_map[6];
        rename_op(5'd6, 5'd2, 1'b0, 5'd0, 1'b0);
        check("out_rs_ready", out_rs_ready, 1'b0);
        // same-cycle writeback goes through the bypass
        present_req(5'd6, 5'd2, 1'b0, 5'd0, 1'b0, 1'b1, p);
        finish_req();
        check("out_rs_ready", out_rs_ready, 1'b1);
    endtask

    task automatic exhaust_free_list();
        rename_pkg::phys_reg_t first_old;
        reset_dut();
        for (int i = 0; i < rename_pkg::NUM_FREE; i++) begin
            rename_op(rand_reg(), rand_reg(), 1'b1, rand_reg(), 1'b0);
        end
        first_old = al_q[0];
        present_req(5'd1, 5'd2, 1'b1, rand_reg(), 1'b0, 1'b0, '0);
        repeat (3) begin
            @(negedge clk);
            check("ren_stall", ren_stall, 1'b1);
        end
        commit_one();
        finish_req();
        check("out_rw_phys", out_rw_phys, first_old);
    endtask

    task automatic restore_after_mispredict();
        rename_pkg::phys_reg_t branch_map [rename_pkg::NUM_ARCH_REGS];
        rename_pkg::phys_reg_t first_after;
        reset_dut();
        rename_op(5'd1, 5'd2, 1'b1, rand_reg(), 1'b0);
        rename_op(5'd3, 5'd4, 1'b1, rand_reg(), 1'b0);
        // linking branch that writes r31
        rename_op(5'd5, 5'd6, 1'b1, 5'd31, 1'b1);
        for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
            branch_map[i] = ref_map[i];
        end
        first_after = free_q[0];
        repeat (5) rename_op(rand_reg(), rand_reg(), 1'b1, rand_reg(), 1'b0);
        resolve_branch(1'b1);
        for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i += 2) begin
            rename_op(rename_pkg::arch_reg_t'(i), rename_pkg::arch_reg_t'(i + 1),
                      1'b0, 5'd0, 1'b0);
            check("out_rs_phys", out_rs_phys, branch_map[i]);
            check("out_rt_phys", out_rt_phys, branch_map[i + 1]);
        end
        rename_op(5'd7, 5'd8, 1'b1, rand_reg(), 1'b0);
        check("out_rw_phys", out_rw_phys, first_after);
    endtask

    task automatic fill_checkpoints();
        reset_dut();
        rename_op(5'd1, 5'd2, 1'b0, 5'd0, 1'b1);
        rename_op(5'd3, 5'd4, 1'b1, rand_reg(), 1'b1);
        present_req(5'd5, 5'd6, 1'b0, 5'd0, 1'b1, 1'b0, '0);
        repeat (2) begin
            @(negedge clk);
            check("ren_stall", ren_stall, 1'b1);
        end
        // oldest branch predicted correctly releases one slot
        resolve_branch(1'b0);
        finish_req();
    endtask

    initial begin
        rst_n              = 1'b0;
        ren_valid          = 1'b0;
        ren_rs             = '0;
        ren_rt             = '0;
        ren_uses_rw        = 1'b0;
        ren_rw             = '0;
        ren_is_branch      = 1'b0;
        wb_valid           = 1'b0;
        wb_phys            = '0;
        commit_valid       = 1'b0;
        resolve_valid      = 1'b0;
        resolve_mispredict = 1'b0;
        lookup_after_reset();
        writeback_sets_ready();
        exhaust_free_list();
        restore_after_mispredict();
        fill_checkpoints();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
logic/rename_pkg.sv
logic/phys_free_list.sv
logic/active_list.sv
logic/map_table.sv
logic/busy_table.sv
logic/rename_ctrl.sv
logic/rename_top.sv
dv/rename_tb.sv

// File: logic/active_list.sv
/*
 * active list
 * in-order record of the mapping displaced by each renamed destination,
 * popped at commit, tail pulled back on a mispredict
 */
`timescale 1ns/100ps
`default_nettype none

module active_list (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   alloc,
    input  rename_pkg::phys_reg_t  old_phys,
    input  logic                   commit,
    input  logic                   restore,
    input  rename_pkg::queue_ptr_t restore_tail,
    output rename_pkg::queue_ptr_t tail,
    output rename_pkg::phys_reg_t  commit_phys
);

    // old mappings in program order
    rename_pkg::phys_reg_t  al_mem [rename_pkg::NUM_FREE];
    rename_pkg::queue_ptr_t head;

    // oldest displaced register, goes back to the free list on commit
    assign commit_phys = al_mem[head[4:0]];

    // entry storage, written only on accept
    // the free list bounds occupancy so no full check here
    always_ff @(posedge clk) begin
        if (alloc) begin
            al_mem[tail[4:0]] <= old_phys;
        end
    end

    // pointers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
        end else begin
            // squash entries younger than the branch
            if (restore) begin
                tail <= restore_tail;
            end else if (alloc) begin
                tail <= tail + rename_pkg::queue_ptr_t'(1);
            end

            // commit is always older than any branch in flight
            if (commit) begin
                head <= head + rename_pkg::queue_ptr_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/busy_table.sv
/*
 * busy table
 * one pending bit per physical register, with writeback bypass on reads
 */
`timescale 1ns/100ps
`default_nettype none

module busy_table (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  set,
    input  rename_pkg::phys_reg_t set_phys,
    input  logic                  wb_valid,
    input  rename_pkg::phys_reg_t wb_phys,
    input  rename_pkg::phys_reg_t rs_phys,
    input  rename_pkg::phys_reg_t rt_phys,
    output logic                  rs_ready,
    output logic                  rt_ready
);

    // high while the value is still being produced
    logic [rename_pkg::NUM_PHYS_REGS-1:0] busy;

    // a writeback this cycle counts as ready already
    assign rs_ready = ~busy[rs_phys] | (wb_valid & (wb_phys == rs_phys));
    assign rt_ready = ~busy[rt_phys] | (wb_valid & (wb_phys == rt_phys));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (wb_valid) begin
                busy[wb_phys] <= 1'b0;
            end
            // fresh destination, busy from next cycle
            // squashed registers get set again here when reused
            if (set) begin
                busy[set_phys] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/map_table.sv
/*
 * register map table
 * architectural to physical map with combinational lookups,
 * plus in-order branch checkpoint slots for mispredict recovery
 */
`timescale 1ns/100ps
`default_nettype none

module map_table (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rename_pkg::arch_reg_t  rs,
    input  rename_pkg::arch_reg_t  rt,
    input  rename_pkg::arch_reg_t  rw,
    input  logic                   write,
    input  rename_pkg::phys_reg_t  new_phys,
    input  logic                   take_ckpt,
    input  rename_pkg::queue_ptr_t free_head,
    input  rename_pkg::queue_ptr_t al_tail,
    input  logic                   resolve_valid,
    input  logic                   mispredict,
    output rename_pkg::phys_reg_t  rs_phys,
    output rename_pkg::phys_reg_t  rt_phys,
    output rename_pkg::phys_reg_t  rw_old,
    output logic                   ckpt_full,
    output logic                   restore,
    output rename_pkg::queue_ptr_t saved_free_head,
    output rename_pkg::queue_ptr_t saved_al_tail
);

    rename_pkg::phys_reg_t  rmt      [rename_pkg::NUM_ARCH_REGS];
    rename_pkg::phys_reg_t  rmt_next [rename_pkg::NUM_ARCH_REGS];

    // checkpoint payload
    rename_pkg::phys_reg_t  ckpt_rmt  [rename_pkg::NUM_CHECKPOINTS][rename_pkg::NUM_ARCH_REGS];
    rename_pkg::queue_ptr_t ckpt_head [rename_pkg::NUM_CHECKPOINTS];
    rename_pkg::queue_ptr_t ckpt_tail [rename_pkg::NUM_CHECKPOINTS];

    // slot pointers, oldest unresolved at ckpt_rd
    rename_pkg::ckpt_idx_t  ckpt_wr;
    rename_pkg::ckpt_idx_t  ckpt_rd;
    logic [1:0]             ckpt_count;

    // lookups see the map before this instruction's own write
    assign rs_phys = rmt[rs];
    assign rt_phys = rmt[rt];
    assign rw_old  = rmt[rw];

    assign ckpt_full = (ckpt_count == 2'(rename_pkg::NUM_CHECKPOINTS));

    // resolve always refers to the oldest slot
    assign restore         = resolve_valid & mispredict;
    assign saved_free_head = ckpt_head[ckpt_rd];
    assign saved_al_tail   = ckpt_tail[ckpt_rd];

    // map as it stands after the accepted write
    always_comb begin
        rmt_next = rmt;
        if (write) begin
            rmt_next[rw] = new_phys;
        end
    end

    // snapshot includes the branch's own destination, if any
    always_ff @(posedge clk) begin
        if (take_ckpt) begin
            ckpt_rmt[ckpt_wr]  <= rmt_next;
            ckpt_head[ckpt_wr] <= free_head + rename_pkg::queue_ptr_t'(write);
            ckpt_tail[ckpt_wr] <= al_tail + rename_pkg::queue_ptr_t'(write);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // identity map, ri -> pi
            for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
                rmt[i] <= rename_pkg::phys_reg_t'(i);
            end
            ckpt_wr    <= '0;
            ckpt_rd    <= '0;
            ckpt_count <= '0;
        end else if (restore) begin
            // roll back and drop every slot, younger branches are squashed
            rmt        <= ckpt_rmt[ckpt_rd];
            ckpt_wr    <= ckpt_rd;
            ckpt_count <= '0;
        end else begin
            rmt <= rmt_next;
            if (take_ckpt) begin
                ckpt_wr <= ckpt_wr + rename_pkg::ckpt_idx_t'(1);
            end
            // correct prediction releases the oldest slot
            if (resolve_valid) begin
                ckpt_rd <= ckpt_rd + rename_pkg::ckpt_idx_t'(1);
            end
            ckpt_count <= ckpt_count + 2'(take_ckpt) - 2'(resolve_valid);
        end
    end

endmodule

`default_nettype wire

// File: logic/phys_free_list.sv
/*
 * physical register free list
 * circular queue of free registers, popped on allocation, pushed on commit,
 * head reloaded from a branch checkpoint on mispredict
 */
`timescale 1ns/100ps
`default_nettype none

module phys_free_list (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   alloc,
    input  logic                   push,
    input  rename_pkg::phys_reg_t  push_phys,
    input  logic                   restore,
    input  rename_pkg::queue_ptr_t restore_head,
    output rename_pkg::phys_reg_t  head_phys,
    output rename_pkg::queue_ptr_t head,
    output logic                   empty
);

    // queue storage, one free physical register per slot
    rename_pkg::phys_reg_t  fl_mem [rename_pkg::NUM_FREE];
    rename_pkg::queue_ptr_t tail;

    // register handed out on the next allocation
    assign head_phys = fl_mem[head[4:0]];

    // same index and same wrap bit means nothing left
    // same index with opposite wrap bit is a full queue
    assign empty = (head == tail);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // p32..p63 start free, p32 at the head
            for (int i = 0; i < rename_pkg::NUM_FREE; i++) begin
                fl_mem[i] <= rename_pkg::phys_reg_t'(rename_pkg::NUM_FREE + i);
            end
            head <= '0;
            // tail one full lap ahead of head
            tail <= rename_pkg::queue_ptr_t'(rename_pkg::NUM_FREE);
        end else begin
            // head side
            // a mispredict hands back everything popped since the branch
            // entries are still in place since tail never passed them
            if (restore) begin
                head <= restore_head;
            end else if (alloc) begin
                head <= head + rename_pkg::queue_ptr_t'(1);
            end

            // tail side, commit returns the displaced mapping
            // still done on a mispredict cycle, the commit is older
            if (push) begin
                fl_mem[tail[4:0]] <= push_phys;
                tail <= tail + rename_pkg::queue_ptr_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/rename_ctrl.sv
/*
 * rename control
 * stall and accept decisions for the request handshake,
 * and the one-cycle registered rename result
 */
`timescale 1ns/100ps
`default_nettype none

module rename_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ren_valid,
    input  logic                  ren_uses_rw,
    input  logic                  ren_is_branch,
    input  logic                  free_empty,
    input  logic                  ckpt_full,
    input  logic                  mispredict_now,
    input  rename_pkg::phys_reg_t rs_phys,
    input  rename_pkg::phys_reg_t rt_phys,
    input  rename_pkg::phys_reg_t new_phys,
    input  rename_pkg::phys_reg_t rw_old,
    input  logic                  rs_ready,
    input  logic                  rt_ready,
    output logic                  ren_stall,
    output logic                  alloc,
    output logic                  take_ckpt,
    output logic                  out_valid,
    output rename_pkg::phys_reg_t out_rs_phys,
    output rename_pkg::phys_reg_t out_rt_phys,
    output rename_pkg::phys_reg_t out_rw_phys,
    output rename_pkg::phys_reg_t out_old_phys,
    output logic                  out_rs_ready,
    output logic                  out_rt_ready
);

    logic accept;
    logic no_free_reg;
    logic no_ckpt_slot;

    // resource checks only matter for the kind of request presented
    assign no_free_reg  = ren_valid & ren_uses_rw & free_empty;
    assign no_ckpt_slot = ren_valid & ren_is_branch & ckpt_full;

    // block new requests while the map is being rolled back
    assign ren_stall = no_free_reg | no_ckpt_slot | mispredict_now;

    assign accept = ren_valid & ~ren_stall;

    // structures only move for the parts the instruction needs
    assign alloc     = accept & ren_uses_rw;
    assign take_ckpt = accept & ren_is_branch;

    // result valid for exactly one cycle after accept
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= accept;
        end
    end

    // result payload
    // ready bits sampled at accept, wb bypass already applied
    always_ff @(posedge clk) begin
        if (accept) begin
            out_rs_phys  <= rs_phys;
            out_rt_phys  <= rt_phys;
            out_rw_phys  <= new_phys;
            out_old_phys <= rw_old;
            out_rs_ready <= rs_ready;
            out_rt_ready <= rt_ready;
        end
    end

endmodule

`default_nettype wire

// File: logic/rename_pkg.sv
/*
 * rename package
 * register index types and structure sizes shared by the rename stage
 */
`default_nettype none

package rename_pkg;

    // architectural and physical register file sizes
    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PHYS_REGS = 64;

    // depth of the free list and of the active list
    localparam int NUM_FREE = 32;

    // unresolved branches held at once
    localparam int NUM_CHECKPOINTS = 2;

    // architectural register index, r0..r31
    typedef logic [4:0] arch_reg_t;

    // physical register index, p0..p63
    typedef logic [5:0] phys_reg_t;

    // queue pointer, 5-bit index plus wrap bit in the msb
    typedef logic [5:0] queue_ptr_t;

    // checkpoint slot index
    typedef logic [0:0] ckpt_idx_t;

endpackage

`default_nettype wire

// File: logic/rename_top.sv
/*
 * register rename stage top level
 * ties the map table, free list, active list, busy table and control
 */
`timescale 1ns/100ps
`default_nettype none

module rename_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // rename request
    input  logic                  ren_valid,
    input  rename_pkg::arch_reg_t ren_rs,
    input  rename_pkg::arch_reg_t ren_rt,
    input  logic                  ren_uses_rw,
    input  rename_pkg::arch_reg_t ren_rw,
    input  logic                  ren_is_branch,
    output logic                  ren_stall,
    // writeback, commit, branch resolve
    input  logic                  wb_valid,
    input  rename_pkg::phys_reg_t wb_phys,
    input  logic                  commit_valid,
    input  logic                  resolve_valid,
    input  logic                  resolve_mispredict,
    // rename result
    output logic                  out_valid,
    output rename_pkg::phys_reg_t out_rs_phys,
    output rename_pkg::phys_reg_t out_rt_phys,
    output rename_pkg::phys_reg_t out_rw_phys,
    output rename_pkg::phys_reg_t out_old_phys,
    output logic                  out_rs_ready,
    output logic                  out_rt_ready
);

    logic                   alloc;
    logic                   take_ckpt;
    logic                   mispredict_now;
    logic                   ckpt_full;
    logic                   free_empty;
    logic                   rs_ready;
    logic                   rt_ready;
    rename_pkg::phys_reg_t  rs_phys;
    rename_pkg::phys_reg_t  rt_phys;
    rename_pkg::phys_reg_t  rw_old;
    rename_pkg::phys_reg_t  free_phys;
    rename_pkg::phys_reg_t  al_old_phys;
    rename_pkg::queue_ptr_t free_head;
    rename_pkg::queue_ptr_t al_tail;
    rename_pkg::queue_ptr_t saved_free_head;
    rename_pkg::queue_ptr_t saved_al_tail;

    rename_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .ren_valid(ren_valid), .ren_uses_rw(ren_uses_rw), .ren_is_branch(ren_is_branch),
        .free_empty(free_empty), .ckpt_full(ckpt_full), .mispredict_now(mispredict_now),
        .rs_phys(rs_phys), .rt_phys(rt_phys), .new_phys(free_phys), .rw_old(rw_old),
        .rs_ready(rs_ready), .rt_ready(rt_ready),
        .ren_stall(ren_stall), .alloc(alloc), .take_ckpt(take_ckpt),
        .out_valid(out_valid), .out_rs_phys(out_rs_phys), .out_rt_phys(out_rt_phys),
        .out_rw_phys(out_rw_phys), .out_old_phys(out_old_phys),
        .out_rs_ready(out_rs_ready), .out_rt_ready(out_rt_ready)
    );

    // mispredict strobe originates here and fans out as restore
    map_table u_map (
        .clk(clk), .rst_n(rst_n),
        .rs(ren_rs), .rt(ren_rt), .rw(ren_rw),
        .write(alloc), .new_phys(free_phys), .take_ckpt(take_ckpt),
        .free_head(free_head), .al_tail(al_tail),
        .resolve_valid(resolve_valid), .mispredict(resolve_mispredict),
        .rs_phys(rs_phys), .rt_phys(rt_phys), .rw_old(rw_old),
        .ckpt_full(ckpt_full), .restore(mispredict_now),
        .saved_free_head(saved_free_head), .saved_al_tail(saved_al_tail)
    );

    phys_free_list u_free (
        .clk(clk), .rst_n(rst_n),
        .alloc(alloc), .push(commit_valid), .push_phys(al_old_phys),
        .restore(mispredict_now), .restore_head(saved_free_head),
        .head_phys(free_phys), .head(free_head), .empty(free_empty)
    );

    active_list u_active (
        .clk(clk), .rst_n(rst_n),
        .alloc(alloc), .old_phys(rw_old), .commit(commit_valid),
        .restore(mispredict_now), .restore_tail(saved_al_tail),
        .tail(al_tail), .commit_phys(al_old_phys)
    );

    busy_table u_busy (
        .clk(clk), .rst_n(rst_n),
        .set(alloc), .set_phys(free_phys),
        .wb_valid(wb_valid), .wb_phys(wb_phys),
        .rs_phys(rs_phys), .rt_phys(rt_phys),
        .rs_ready(rs_ready), .rt_ready(rt_ready)
    );

endmodule

`default_nettype wire
